// ==== source/mult_pkg.sv ====
// shared definitions for the pipelined integer multiply unit
// widths, stage and step counts, opcodes and the stage bus layout

`default_nettype none

package mult_pkg;

    // operand and result width
    localparam int xlen = 32;

    // pipeline shape
    // stage count and step count together set the booth width
    localparam int num_stages = 8;
    localparam int steps_per_stage = 5;

    // extended operand width, one radix-2 step per bit
    localparam int booth_w = num_stages * steps_per_stage;

    // request tag width
    localparam int tag_w = 4;

    // booth width must hold an unsigned xlen operand plus a sign bit
    localparam bit booth_w_ok = (booth_w >= xlen + 1);

    // multiply opcodes
    // mul returns the low word, the rest return the high word
    typedef enum logic [1:0] {
        mul    = 2'b00,
        mulh   = 2'b01,
        mulhsu = 2'b10,
        mulhu  = 2'b11
    } mult_func_e;

    // data carried between booth stages
    typedef struct packed {
        // {AC, QR}, partial product over multiplier
        logic [2*booth_w-1:0] acc;
        // q-1 bit right of QR
        logic                 phantom;
        // extended multiplicand, BR
        logic [booth_w-1:0]   mcand;
    } booth_bus_t;

    // per-request sideband that rides beside the data
    typedef struct packed {
        mult_func_e       func;
        logic [tag_w-1:0] tag;
    } req_side_t;

endpackage

`default_nettype wire

// ==== source/mult_operand_prep.sv ====
// operand preparation for the multiply pipeline
// extends both operands per opcode and registers the first stage bus

`timescale 1ns/1ps
`default_nettype none

module mult_operand_prep (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        load,
    input  wire logic [mult_pkg::xlen-1:0]   a,
    input  wire logic [mult_pkg::xlen-1:0]   b,
    input  wire mult_pkg::mult_func_e        func,
    output mult_pkg::booth_bus_t             stage_bus
);

    // signedness of each operand for this opcode
    logic a_signed;
    logic b_signed;

    // extended operands
    logic [mult_pkg::booth_w-1:0] a_ext;
    logic [mult_pkg::booth_w-1:0] b_ext;

    // multiplicand is unsigned only for mulhu
    // multiplier is signed only for mul and mulh
    always_comb begin
        a_signed = (func != mult_pkg::mulhu);
        b_signed = (func == mult_pkg::mul) || (func == mult_pkg::mulh);
    end

    // replicate the sign bit, or zeros, up to the booth width
    always_comb begin
        a_ext = {{(mult_pkg::booth_w - mult_pkg::xlen){a[mult_pkg::xlen-1] & a_signed}}, a};
        b_ext = {{(mult_pkg::booth_w - mult_pkg::xlen){b[mult_pkg::xlen-1] & b_signed}}, b};
    end

    // initial bus: AC cleared, multiplier in QR, q-1 cleared
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage_bus <= '0;
        end else if (load) begin
            stage_bus.acc     <= {{mult_pkg::booth_w{1'b0}}, b_ext};
            stage_bus.phantom <= 1'b0;
            stage_bus.mcand   <= a_ext;
        end
    end

endmodule

`default_nettype wire

// ==== source/booth_stage.sv ====
// one stage of the radix-2 booth multiply pipeline
// runs steps_per_stage add/subtract-and-shift steps on {AC, QR, q-1}
// and registers the updated accumulator when started

`timescale 1ns/1ps
`default_nettype none

module booth_stage (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  wire mult_pkg::booth_bus_t stage_in,
    output mult_pkg::booth_bus_t      stage_out
);

    // working word {AC, QR, q-1}, one bit wider than the accumulator
    // signed so the right shift keeps the AC sign
    logic signed [2*mult_pkg::booth_w:0] work;

    // upper half of the working word, the AC field
    logic [mult_pkg::booth_w-1:0] ac_cur;

    always_comb begin
        work = {stage_in.acc, stage_in.phantom};
        ac_cur = '0;

        for (int i = 0; i < mult_pkg::steps_per_stage; i++) begin
            ac_cur = work[2*mult_pkg::booth_w:mult_pkg::booth_w+1];

            // recode the lowest QR bit against q-1
            case (work[1:0])
                // start of a run of ones
                2'b10: begin
                    work[2*mult_pkg::booth_w:mult_pkg::booth_w+1] =
                        ac_cur - stage_in.mcand;
                end
                // end of a run of ones
                2'b01: begin
                    work[2*mult_pkg::booth_w:mult_pkg::booth_w+1] =
                        ac_cur + stage_in.mcand;
                end
                // 00 and 11 only shift
                default: begin
                end
            endcase

            // arithmetic shift of the whole word
            work = work >>> 1;
        end
    end

    // register the step result, multiplicand passes through unchanged
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage_out <= '0;
        end else if (start) begin
            stage_out.acc     <= work[2*mult_pkg::booth_w:1];
            stage_out.phantom <= work[0];
            stage_out.mcand   <= stage_in.mcand;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult_control.sv ====
// control for the multiply pipeline
// tracks a valid bit and the func/tag sideband for every stage register,
// starts each booth stage only when it holds a live request, and flushes

`timescale 1ns/1ps
`default_nettype none

module mult_control (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         req,
    input  wire logic                         flush,
    input  wire mult_pkg::mult_func_e         func,
    input  wire logic [mult_pkg::tag_w-1:0]   tag,
    output logic                              prep_load,
    output logic [mult_pkg::num_stages-1:0]   stage_start,
    output logic                              finish_load,
    output mult_pkg::mult_func_e              finish_func,
    output logic                              result_valid,
    output logic [mult_pkg::tag_w-1:0]        result_tag
);

    // valid[0] covers the operand register, valid[k] covers booth stage k
    logic [mult_pkg::num_stages:0] valid;

    // sideband for each stage register, same indexing as valid
    mult_pkg::req_side_t side_q [0:mult_pkg::num_stages];

    // a request in the same cycle as a flush is dropped
    assign prep_load = req & ~flush;

    // stage k loads from register k-1 when that register is live
    assign stage_start = valid[mult_pkg::num_stages-1:0];

    // last booth stage holds a finished product
    assign finish_load = valid[mult_pkg::num_stages];
    assign finish_func = side_q[mult_pkg::num_stages].func;

    // valid shift and result strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid        <= '0;
            result_valid <= 1'b0;
        end else if (flush) begin
            // everything in flight is cancelled, the last stage too
            valid        <= '0;
            result_valid <= 1'b0;
        end else begin
            valid        <= {valid[mult_pkg::num_stages-1:0], prep_load};
            result_valid <= finish_load;
        end
    end

    // sideband follows the data, one step per live stage
    always_ff @(posedge clock) begin
        if (prep_load) begin
            side_q[0].func <= func;
            side_q[0].tag  <= tag;
        end
        for (int k = 1; k <= mult_pkg::num_stages; k++) begin
            if (valid[k-1]) begin
                side_q[k] <= side_q[k-1];
            end
        end
    end

    // tag of the finished request, taken with the result word
    always_ff @(posedge clock) begin
        if (finish_load) begin
            result_tag <= side_q[mult_pkg::num_stages].tag;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult_result_select.sv ====
// result stage of the multiply pipeline
// picks the low or high product word per opcode and registers it

`timescale 1ns/1ps
`default_nettype none

module mult_result_select (
    input  wire logic                            clock,
    input  wire logic                            reset,
    input  wire logic                            load,
    input  wire mult_pkg::mult_func_e            func,
    input  wire logic [2*mult_pkg::booth_w-1:0]  product,
    output logic [mult_pkg::xlen-1:0]            result
);

    // selected word before the output register
    logic [mult_pkg::xlen-1:0] word_sel;

    // mul wants the low word
    // mulh, mulhsu and mulhu want the high word
    // both are exact since the extended operands fit the booth width
    always_comb begin
        if (func == mult_pkg::mul) begin
            word_sel = product[mult_pkg::xlen-1:0];
        end else begin
            word_sel = product[2*mult_pkg::xlen-1:mult_pkg::xlen];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (load) begin
            result <= word_sel;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult_unit.sv ====
// pipelined integer multiply unit for the execute stage
// operand prep, eight booth stages and a result stage, 9 cycle latency,
// one request per cycle, flush cancels everything in flight

`timescale 1ns/1ps
`default_nettype none

module mult_unit (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         req,
    input  wire logic                         flush,
    input  wire logic [mult_pkg::xlen-1:0]    a,
    input  wire logic [mult_pkg::xlen-1:0]    b,
    input  wire mult_pkg::mult_func_e         func,
    input  wire logic [mult_pkg::tag_w-1:0]   tag,
    output logic                              result_valid,
    output logic [mult_pkg::xlen-1:0]         result,
    output logic [mult_pkg::tag_w-1:0]        result_tag
);

    // control wires
    logic                             prep_load;
    logic [mult_pkg::num_stages-1:0]  stage_start;
    logic                             finish_load;
    mult_pkg::mult_func_e             finish_func;

    // stage buses, bus[0] from operand prep, bus[k] from booth stage k
    mult_pkg::booth_bus_t bus [0:mult_pkg::num_stages];

    mult_control i_mult_control (
        .clock        (clock),
        .reset        (reset),
        .req          (req),
        .flush        (flush),
        .func         (func),
        .tag          (tag),
        .prep_load    (prep_load),
        .stage_start  (stage_start),
        .finish_load  (finish_load),
        .finish_func  (finish_func),
        .result_valid (result_valid),
        .result_tag   (result_tag)
    );

    mult_operand_prep i_mult_operand_prep (
        .clock     (clock),
        .reset     (reset),
        .load      (prep_load),
        .a         (a),
        .b         (b),
        .func      (func),
        .stage_bus (bus[0])
    );

    // booth chain, stage k+1 started by stage_start[k]
    for (genvar k = 0; k < mult_pkg::num_stages; k++) begin : g_stage
        booth_stage i_booth_stage (
            .clock     (clock),
            .reset     (reset),
            .start     (stage_start[k]),
            .stage_in  (bus[k]),
            .stage_out (bus[k+1])
        );
    end

    mult_result_select i_mult_result_select (
        .clock   (clock),
        .reset   (reset),
        .load    (finish_load),
        .func    (finish_func),
        .product (bus[mult_pkg::num_stages].acc),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== test/mult_unit_props.sv ====
// timing and reset properties of the multiply unit
// bound into mult_unit, reports only through failing assertions

`timescale 1ns/1ps
`default_nettype none

module mult_unit_props (
    input wire logic clock,
    input wire logic reset,
    input wire logic req,
    input wire logic flush,
    input wire logic result_valid
);

    // request to result, in clock edges
    localparam int latency = 9;

    logic accepted;
    // flush seen on each of the last latency edges
    logic [latency-1:0] flush_hist;

    assign accepted = req & ~flush;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flush_hist <= '0;
        end else begin
            flush_hist <= {flush_hist[latency-2:0], flush};
        end
    end

    // the result register is sampled one edge after it loads
    a_latency: assert property (@(posedge clock) disable iff (reset)
        ($past(accepted, latency + 1) && flush_hist == '0) |-> result_valid)
        else $error("accepted request gave no result after %0d cycles", latency);

    a_reset_low: assert property (@(posedge clock) reset |-> !result_valid)
        else $error("result_valid high while reset is held");

    a_no_spurious: assert property (@(posedge clock) disable iff (reset)
        result_valid |-> $past(accepted, latency + 1))
        else $error("result_valid without a request %0d cycles earlier", latency);

endmodule

bind mult_unit mult_unit_props i_mult_unit_props (
    .clock        (clock),
    .reset        (reset),
    .req          (req),
    .flush        (flush),
    .result_valid (result_valid)
);

`default_nettype wire

// ==== test/mult_unit_tb.sv ====
// testbench for the pipelined multiply unit
// directed and random requests checked against a reference product model

`timescale 1ns/1ps
`default_nettype none

module mult_unit_tb;

    localparam int latency = 9;
    localparam int reset_cycles = 8;
    localparam int n_random = 200;
    localparam int n_random_high = 60;
    localparam int n_burst = 40;
    localparam int drain_limit = latency + 6;
    // requests of all tests, one drain per test, plus slack
    localparam int watchdog_cycles = reset_cycles + 4 * 36 + n_random + 3 * n_random_high
                                     + n_burst + 7 + 5 * (drain_limit + 20) + 200;

    typedef struct packed {
        logic [mult_pkg::xlen-1:0]  word;
        logic [mult_pkg::tag_w-1:0] tag;
        int unsigned                cycle;
    } expect_t;

    localparam logic [31:0] corners [0:5] = '{32'h0, 32'h1, 32'hffffffff,
                                              32'h80000000, 32'h7fffffff, 32'h12345678};

    logic                       clock;
    logic                       reset;
    logic                       req;
    logic                       flush;
    logic [mult_pkg::xlen-1:0]  a;
    logic [mult_pkg::xlen-1:0]  b;
    mult_pkg::mult_func_e       func;
    logic [mult_pkg::tag_w-1:0] tag;
    logic                       result_valid;
    logic [mult_pkg::xlen-1:0]  result;
    logic [mult_pkg::tag_w-1:0] result_tag;

    expect_t                    exp_q [$];
    logic [mult_pkg::tag_w-1:0] next_tag = '0;
    int unsigned                cycle = 0;
    int                         errors = 0;
    int                         checks = 0;
    int                         tests = 0;
    int                         test_errors_start = 0;

    mult_unit i_mult_unit (.*);

    always #5 clock = ~clock;

    // full product with per-operand signedness, low or high word
    function automatic logic [31:0] expected_word(input logic [31:0] op_a,
                                                  input logic [31:0] op_b,
                                                  input mult_pkg::mult_func_e op_func);
        logic signed [32:0] ax;
        logic signed [32:0] bx;
        logic signed [65:0] prod;
        ax = {op_a[31] & (op_func != mult_pkg::mulhu), op_a};
        bx = {op_b[31] & (op_func == mult_pkg::mul || op_func == mult_pkg::mulh), op_b};
        prod = ax * bx;
        return (op_func == mult_pkg::mul) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic value_error(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic other_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic send(input logic [31:0] op_a, input logic [31:0] op_b,
                        input mult_pkg::mult_func_e op_func);
        @(negedge clock);
        req = 1'b1;
        flush = 1'b0;
        a = op_a;
        b = op_b;
        func = op_func;
        tag = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    // stop requesting and wait for everything in flight
    task automatic drain();
        int n;
        n = 0;
        @(negedge clock);
        req = 1'b0;
        while (exp_q.size() != 0 && n < drain_limit) begin
            @(negedge clock);
            n++;
        end
        checks++;
        assert (exp_q.size() == 0)
            else other_error($sformatf("%0d results never arrived", exp_q.size()));
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_errors_start);
        test_errors_start = errors;
    endtask

    // requests are taken on the rising edge, flush empties the model
    always @(posedge clock) begin : model
        expect_t entry;
        cycle = cycle + 1;
        if (reset || flush) begin
            exp_q.delete();
        end else if (req) begin
            entry.word = expected_word(a, b, func);
            entry.tag = tag;
            entry.cycle = cycle;
            exp_q.push_back(entry);
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clock) begin : monitor
        expect_t head;
        if (reset) begin
            checks++;
            assert (!result_valid) else other_error("result_valid high during reset");
        end else if (result_valid) begin
            checks++;
            assert (exp_q.size() != 0) else other_error("result with no live request");
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checks += 2;
                assert (result === head.word && result_tag === head.tag)
                    else value_error($sformatf("result %h tag %h, expected %h tag %h",
                                               result, result_tag, head.word, head.tag));
                assert (cycle == head.cycle + latency)
                    else other_error($sformatf("result came %0d cycles after its request",
                                               cycle - head.cycle));
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        int i;
        int j;
        int k;
        clock = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        flush = 1'b0;
        a = '0;
        b = '0;
        func = mult_pkg::mul;
        tag = '0;
        void'($urandom(32'h42fc));
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        // idle after reset, no result may appear
        repeat (latency + 4) @(negedge clock);
        finish_test("reset");

        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 6; j++) begin
                send(corners[i], corners[j], mult_pkg::mul);
            end
        end
        repeat (n_random) send($urandom(), $urandom(), mult_pkg::mul);
        drain();
        finish_test("mul");

        // k walks mulh, mulhsu, mulhu
        for (k = 1; k < 4; k++) begin
            for (i = 0; i < 6; i++) begin
                for (j = 0; j < 6; j++) begin
                    send(corners[i], corners[j], mult_pkg::mult_func_e'(k[1:0]));
                end
            end
            repeat (n_random_high) send($urandom(), $urandom(), mult_pkg::mult_func_e'(k[1:0]));
        end
        drain();
        finish_test("high word");

        // one request per cycle, opcodes mixed, tags counting
        for (i = 0; i < n_burst; i++) begin
            send($urandom(), $urandom(), mult_pkg::mult_func_e'(i[1:0]));
        end
        drain();
        finish_test("throughput");

        repeat (5) send($urandom(), $urandom(), mult_pkg::mulh);
        // flush with a request in the same cycle, both dropped
        @(negedge clock);
        flush = 1'b1;
        req = 1'b1;
        a = 32'h0000_0007;
        b = 32'h0000_0009;
        @(negedge clock);
        flush = 1'b0;
        req = 1'b0;
        repeat (latency + 5) @(negedge clock);
        send(32'hffff_fffd, 32'h0000_0005, mult_pkg::mul);
        drain();
        finish_test("flush");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mult_unit.f ====
source/mult_pkg.sv
source/mult_operand_prep.sv
source/booth_stage.sv
source/mult_control.sv
source/mult_result_select.sv
source/mult_unit.sv
test/mult_unit_props.sv
test/mult_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the multiply unit testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f mult_unit.f --top-module mult_unit_tb \
    -Mdir "$build_dir" -o mult_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/mult_unit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log_file"; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "NO ERRORS" "$log_file"; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"
exit 0
